// File: io_hub_pkg.sv
`default_nettype none

package io_hub_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [7:0]  byte_t;
	typedef logic [2:0]  size_t; // 2 = word, bit 2 = dword

	// order fixed, index into read data and strobes
	typedef enum logic [3:0] {
		DEV_NONE,
		DEV_FLOPPY,
		DEV_DMA,
		DEV_PIC,
		DEV_PIT,
		DEV_PS2,
		DEV_RTC,
		DEV_SOUND,
		DEV_UART1,
		DEV_UART2,
		DEV_MPU,
		DEV_VGA,
		DEV_JOY,
		DEV_IDE0,
		DEV_IDE1,
		DEV_SYSCTL
	} dev_id_t;

	localparam int    NUM_DEV    = 16;
	localparam byte_t OPEN_BUS   = 8'hFF;
	localparam byte_t SYSCTL_KEY = 8'hA1;

	// port bases
	localparam addr_t PORT_IDE0       = 16'h01F0;
	localparam addr_t PORT_IDE0_CTL   = 16'h03F6;
	localparam addr_t PORT_IDE1       = 16'h0170;
	localparam addr_t PORT_IDE1_CTL   = 16'h0376;
	localparam addr_t PORT_JOY        = 16'h0201;
	localparam addr_t PORT_FDC        = 16'h03F0;
	localparam addr_t PORT_FDC_HI     = 16'h03F4;
	localparam addr_t PORT_FDC_DIR    = 16'h03F7;
	localparam addr_t PORT_DMA_MASTER = 16'h00C0;
	localparam addr_t PORT_DMA_PAGE   = 16'h0080;
	localparam addr_t PORT_DMA_SLAVE  = 16'h0000;
	localparam addr_t PORT_PIC_MASTER = 16'h0020;
	localparam addr_t PORT_PIC_SLAVE  = 16'h00A0;
	localparam addr_t PORT_PIT        = 16'h0040;
	localparam addr_t PORT_PIT_SPK    = 16'h0061; // speaker gate, overlaps ps2 window
	localparam addr_t PORT_PS2_IO     = 16'h0060;
	localparam addr_t PORT_PS2_CTL    = 16'h0090;
	localparam addr_t PORT_RTC        = 16'h0070;
	localparam addr_t PORT_FM         = 16'h0388;
	localparam addr_t PORT_SB         = 16'h0220;
	localparam addr_t PORT_UART1      = 16'h03F8;
	localparam addr_t PORT_UART2      = 16'h02F8;
	localparam addr_t PORT_MPU        = 16'h0330;
	localparam addr_t PORT_VGA_B      = 16'h03B0;
	localparam addr_t PORT_VGA_C      = 16'h03C0;
	localparam addr_t PORT_VGA_D      = 16'h03D0;
	localparam addr_t PORT_SYSCTL     = 16'h8888;

endpackage

`default_nettype wire

// File: io_sel_if.sv
`timescale 1ns/1ps
`default_nettype none

interface io_sel_if;

	io_hub_pkg::dev_id_t sel;       // registered
	logic                io32;      // registered
	io_hub_pkg::addr_t   address;
	logic                read;
	logic                write;
	io_hub_pkg::size_t   datasize;
	io_hub_pkg::data_t   writedata;

	modport decoder (
		output sel,
		output io32,
		output address,
		output read,
		output write,
		output datasize,
		output writedata
	);

	modport user (
		input sel,
		input io32,
		input address,
		input read,
		input write,
		input datasize,
		input writedata
	);

endinterface

`default_nettype wire

// File: io_port_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module io_port_decoder (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire io_hub_pkg::addr_t     bus_address,
	input  wire                        bus_read,
	input  wire                        bus_write,
	input  wire io_hub_pkg::size_t     bus_datasize,
	input  wire io_hub_pkg::data_t     bus_writedata,
	io_sel_if.decoder                  sel
);

	io_hub_pkg::dev_id_t dev_next;
	logic                io32_next;

	// port in window of 2^span ports at base
	function automatic logic hit(
		input io_hub_pkg::addr_t a,
		input io_hub_pkg::addr_t base,
		input int unsigned       span
	);
		return (a >> span) == (base >> span);
	endfunction

	always_comb begin
		if (hit(bus_address, io_hub_pkg::PORT_IDE0, 3) ||
			hit(bus_address, io_hub_pkg::PORT_IDE0_CTL, 0))
			dev_next = io_hub_pkg::DEV_IDE0;
		else if (hit(bus_address, io_hub_pkg::PORT_IDE1, 3) ||
			hit(bus_address, io_hub_pkg::PORT_IDE1_CTL, 0))
			dev_next = io_hub_pkg::DEV_IDE1;
		else if (hit(bus_address, io_hub_pkg::PORT_FDC, 2) ||
			hit(bus_address, io_hub_pkg::PORT_FDC_HI, 1) ||
			hit(bus_address, io_hub_pkg::PORT_FDC_DIR, 0))
			dev_next = io_hub_pkg::DEV_FLOPPY;
		else if (hit(bus_address, io_hub_pkg::PORT_DMA_MASTER, 5) ||
			hit(bus_address, io_hub_pkg::PORT_DMA_PAGE, 4) ||
			hit(bus_address, io_hub_pkg::PORT_DMA_SLAVE, 4))
			dev_next = io_hub_pkg::DEV_DMA;
		else if (hit(bus_address, io_hub_pkg::PORT_PIC_MASTER, 1) ||
			hit(bus_address, io_hub_pkg::PORT_PIC_SLAVE, 1))
			dev_next = io_hub_pkg::DEV_PIC;
		else if (hit(bus_address, io_hub_pkg::PORT_PIT, 2) ||
			hit(bus_address, io_hub_pkg::PORT_PIT_SPK, 0))
			dev_next = io_hub_pkg::DEV_PIT; // ahead of ps2 for 61
		else if (hit(bus_address, io_hub_pkg::PORT_PS2_IO, 3) ||
			hit(bus_address, io_hub_pkg::PORT_PS2_CTL, 4))
			dev_next = io_hub_pkg::DEV_PS2;
		else if (hit(bus_address, io_hub_pkg::PORT_RTC, 1))
			dev_next = io_hub_pkg::DEV_RTC;
		else if (hit(bus_address, io_hub_pkg::PORT_SB, 4) ||
			hit(bus_address, io_hub_pkg::PORT_FM, 2))
			dev_next = io_hub_pkg::DEV_SOUND;
		else if (hit(bus_address, io_hub_pkg::PORT_UART1, 3))
			dev_next = io_hub_pkg::DEV_UART1;
		else if (hit(bus_address, io_hub_pkg::PORT_UART2, 3))
			dev_next = io_hub_pkg::DEV_UART2;
		else if (hit(bus_address, io_hub_pkg::PORT_MPU, 1))
			dev_next = io_hub_pkg::DEV_MPU;
		else if (hit(bus_address, io_hub_pkg::PORT_VGA_B, 4) ||
			hit(bus_address, io_hub_pkg::PORT_VGA_C, 4) ||
			hit(bus_address, io_hub_pkg::PORT_VGA_D, 4))
			dev_next = io_hub_pkg::DEV_VGA;
		else if (hit(bus_address, io_hub_pkg::PORT_JOY, 0))
			dev_next = io_hub_pkg::DEV_JOY;
		else if (hit(bus_address, io_hub_pkg::PORT_SYSCTL, 0))
			dev_next = io_hub_pkg::DEV_SYSCTL;
		else
			dev_next = io_hub_pkg::DEV_NONE;
	end

	// disk data window sits below bit 9, control ports above
	assign io32_next = ((dev_next == io_hub_pkg::DEV_IDE0 || dev_next == io_hub_pkg::DEV_IDE1) &&
		!bus_address[9]) || dev_next == io_hub_pkg::DEV_SYSCTL;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel.sel  <= io_hub_pkg::DEV_NONE;
			sel.io32 <= 1'b0;
		end else begin
			sel.sel  <= dev_next;
			sel.io32 <= io32_next;
		end
	end

	assign sel.address   = bus_address;
	assign sel.read      = bus_read;
	assign sel.write     = bus_write;
	assign sel.datasize  = bus_datasize;
	assign sel.writedata = bus_writedata;

endmodule

`default_nettype wire

// File: sys_ctl_port.sv
`timescale 1ns/1ps
`default_nettype none

module sys_ctl_port #(
	parameter io_hub_pkg::byte_t CTL_RESET_VALUE = 8'hA2
) (
	input  wire               clk_sys,
	input  wire               reset,
	io_sel_if.user            bus,
	output io_hub_pkg::byte_t syscfg
);

	logic in_reset;  // no disk touched since reset
	logic disk_sel;
	logic key_write;

	assign disk_sel = bus.sel == io_hub_pkg::DEV_IDE0 ||
		bus.sel == io_hub_pkg::DEV_IDE1 ||
		bus.sel == io_hub_pkg::DEV_FLOPPY;

	// word write with key in upper byte
	assign key_write = bus.write && bus.sel == io_hub_pkg::DEV_SYSCTL &&
		bus.datasize == io_hub_pkg::size_t'(2) &&
		bus.writedata[15:8] == io_hub_pkg::SYSCTL_KEY;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg   <= CTL_RESET_VALUE;
			in_reset <= 1'b1;
		end else if (disk_sel && in_reset) begin
			syscfg   <= '0; // boot config consumed
			in_reset <= 1'b0;
		end else if (key_write) begin
			syscfg   <= bus.writedata[7:0];
			in_reset <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: io_response.sv
`timescale 1ns/1ps
`default_nettype none

module io_response (
	input  wire                                              clk_sys,
	input  wire                                              reset,
	io_sel_if.user                                           bus,
	input  wire io_hub_pkg::byte_t [io_hub_pkg::NUM_DEV-1:0] dev_readdata8,
	input  wire io_hub_pkg::data_t                           ide0_readdata,
	input  wire io_hub_pkg::data_t                           ide1_readdata,
	input  wire                                              ide0_nodata,
	input  wire                                              ide1_nodata,
	output logic [io_hub_pkg::NUM_DEV-1:0]                   dev_read,
	output logic [io_hub_pkg::NUM_DEV-1:0]                   dev_write,
	output io_hub_pkg::data_t                                bus_readdata,
	output logic                                             bus_io32,
	output logic                                             bus_wait
);

	logic [1:0] disk_nodata;
	logic [1:0] disk_sel;
	logic [1:0] disk_wait;
	logic       data_port;

	assign disk_nodata = {ide1_nodata, ide0_nodata};
	assign disk_sel    = {bus.sel == io_hub_pkg::DEV_IDE1, bus.sel == io_hub_pkg::DEV_IDE0};

	// first data port of the 32-bit window
	assign data_port = bus.io32 && bus.address[2:0] == 3'd0;

	// stretch a disk read until the channel has data
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			disk_wait <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (!disk_nodata[i])
					disk_wait[i] <= 1'b0;
				else if (bus.read && disk_sel[i] && data_port)
					disk_wait[i] <= 1'b1;
			end
		end
	end

	assign bus_wait = |disk_wait;
	assign bus_io32 = bus.io32;

	always_comb begin
		dev_read  = '0;
		dev_write = '0;
		if (bus.sel != io_hub_pkg::DEV_NONE) begin
			dev_read[bus.sel]  = bus.read;
			dev_write[bus.sel] = bus.write;
		end
		// channel keeps reading while it stalls the bus
		dev_read[io_hub_pkg::DEV_IDE0] = dev_read[io_hub_pkg::DEV_IDE0] | disk_wait[0];
		dev_read[io_hub_pkg::DEV_IDE1] = dev_read[io_hub_pkg::DEV_IDE1] | disk_wait[1];
	end

	always_comb begin
		case (bus.sel)
			io_hub_pkg::DEV_IDE0:
				bus_readdata = ide0_readdata;
			io_hub_pkg::DEV_IDE1:
				bus_readdata = ide1_readdata;
			io_hub_pkg::DEV_NONE, io_hub_pkg::DEV_SYSCTL:
				bus_readdata = {24'd0, io_hub_pkg::OPEN_BUS};
			default:
				bus_readdata = {24'd0, dev_readdata8[bus.sel]}; // 8-bit devices
		endcase
	end

endmodule

`default_nettype wire

// File: io_hub.sv
`timescale 1ns/1ps
`default_nettype none

module io_hub #(
	parameter io_hub_pkg::byte_t CTL_RESET_VALUE = 8'hA2
) (
	input  wire                                              clk_sys,
	input  wire                                              reset,

	input  wire io_hub_pkg::addr_t                           bus_address,
	input  wire                                              bus_read,
	input  wire                                              bus_write,
	input  wire io_hub_pkg::size_t                           bus_datasize,
	input  wire io_hub_pkg::data_t                           bus_writedata,
	output wire io_hub_pkg::data_t                           bus_readdata,
	output wire                                              bus_io32,
	output wire                                              bus_wait,

	input  wire io_hub_pkg::byte_t [io_hub_pkg::NUM_DEV-1:0] dev_readdata8,
	input  wire io_hub_pkg::data_t                           ide0_readdata,
	input  wire io_hub_pkg::data_t                           ide1_readdata,
	input  wire                                              ide0_nodata,
	input  wire                                              ide1_nodata,

	output wire io_hub_pkg::dev_id_t                         dev_sel,
	output wire [io_hub_pkg::NUM_DEV-1:0]                    dev_read,
	output wire [io_hub_pkg::NUM_DEV-1:0]                    dev_write,
	output wire io_hub_pkg::byte_t                           syscfg
);

	io_sel_if sel_bus ();

	assign dev_sel = sel_bus.sel;

	io_port_decoder decoder (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus_address   (bus_address),
		.bus_read      (bus_read),
		.bus_write     (bus_write),
		.bus_datasize  (bus_datasize),
		.bus_writedata (bus_writedata),
		.sel           (sel_bus.decoder)
	);

	sys_ctl_port #(
		.CTL_RESET_VALUE (CTL_RESET_VALUE)
	) ctl_port (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (sel_bus.user),
		.syscfg  (syscfg)
	);

	io_response response (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus           (sel_bus.user),
		.dev_readdata8 (dev_readdata8),
		.ide0_readdata (ide0_readdata),
		.ide1_readdata (ide1_readdata),
		.ide0_nodata   (ide0_nodata),
		.ide1_nodata   (ide1_nodata),
		.dev_read      (dev_read),
		.dev_write     (dev_write),
		.bus_readdata  (bus_readdata),
		.bus_io32      (bus_io32),
		.bus_wait      (bus_wait)
	);

endmodule

`default_nettype wire

// File: io_hub_assert.sv
`timescale 1ns/1ps
`default_nettype none

module io_hub_assert (
	input wire                           clk_sys,
	input wire                           reset,
	input wire io_hub_pkg::dev_id_t      dev_sel,
	input wire [io_hub_pkg::NUM_DEV-1:0] dev_read,
	input wire                           bus_wait,
	input wire                           ide0_nodata,
	input wire                           ide1_nodata
);

	int fail_count = 0; // failed assertions so far

	sel_after_reset: assert property (@(posedge clk_sys)
		reset |=> dev_sel == io_hub_pkg::DEV_NONE)
		else begin
			$error("dev_sel not back to none after reset");
			fail_count++;
		end

	// a stall needs a channel without data
	wait_needs_nodata: assert property (@(posedge clk_sys) disable iff (reset)
		bus_wait |-> $past(ide0_nodata || ide1_nodata))
		else begin
			$error("bus_wait high while both channels had data");
			fail_count++;
		end

	read_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(dev_read))
		else begin
			$error("more than one device read strobe high");
			fail_count++;
		end

endmodule

bind io_hub io_hub_assert hub_checks (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.dev_sel     (dev_sel),
	.dev_read    (dev_read),
	.bus_wait    (bus_wait),
	.ide0_nodata (ide0_nodata),
	.ide1_nodata (ide1_nodata)
);

`default_nettype wire

// File: tb_io_hub.sv
`timescale 1ns/1ps
`default_nettype none

module tb_io_hub;

	localparam int RESET_CYCLES = 10;
	localparam int FIELDS       = 8; // words per golden transaction
	localparam int MAX_WORDS    = 512;

	logic                                        clk_sys;
	logic                                        reset;
	io_hub_pkg::addr_t                           bus_address;
	logic                                        bus_read;
	logic                                        bus_write;
	io_hub_pkg::size_t                           bus_datasize;
	io_hub_pkg::data_t                           bus_writedata;
	io_hub_pkg::data_t                           bus_readdata;
	logic                                        bus_io32;
	logic                                        bus_wait;
	io_hub_pkg::byte_t [io_hub_pkg::NUM_DEV-1:0] dev_readdata8;
	io_hub_pkg::data_t                           ide0_readdata;
	io_hub_pkg::data_t                           ide1_readdata;
	logic                                        ide0_nodata;
	logic                                        ide1_nodata;
	io_hub_pkg::dev_id_t                         dev_sel;
	logic [io_hub_pkg::NUM_DEV-1:0]              dev_read;
	logic [io_hub_pkg::NUM_DEV-1:0]              dev_write;
	io_hub_pkg::byte_t                           syscfg;

	logic [31:0] golden [0:MAX_WORDS-1];
	integer      seed;
	int          num_txn;
	int          cycle_count = 0;
	int          cycle_limit = 100000; // replaced once the golden file is loaded

	io_hub #(
		.CTL_RESET_VALUE (8'hA2)
	) dut (.*);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (dut.hub_checks.fail_count != 0) begin
			$display("bound assertion on the DUT failed");
			$display("STATUS: FAIL");
			$fatal(1, "assertion failure");
		end else if (cycle_count >= cycle_limit) begin
			$display("timeout: run still busy after %0d clock cycles", cycle_count);
			$display("STATUS: FAIL");
			$fatal(1, "run did not finish in time");
		end
	end

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, expected);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic new_read_data();
		logic [31:0] rnd;
		for (int i = 0; i < io_hub_pkg::NUM_DEV; i++) begin
			rnd = $random(seed);
			dev_readdata8[i] = rnd[7:0];
		end
		ide0_readdata = $random(seed);
		ide1_readdata = $random(seed);
	endtask

	function automatic logic [io_hub_pkg::NUM_DEV-1:0] strobe_mask(
		input io_hub_pkg::dev_id_t dev, input logic active);
		logic [io_hub_pkg::NUM_DEV-1:0] v;
		v = '0;
		if (active && dev != io_hub_pkg::DEV_NONE)
			v[dev] = 1'b1;
		return v;
	endfunction

	// what the selected device should put on the bus
	function automatic io_hub_pkg::data_t expected_readdata(input io_hub_pkg::dev_id_t dev);
		case (dev)
			io_hub_pkg::DEV_IDE0:   return ide0_readdata;
			io_hub_pkg::DEV_IDE1:   return ide1_readdata;
			io_hub_pkg::DEV_NONE,
			io_hub_pkg::DEV_SYSCTL: return {24'd0, io_hub_pkg::OPEN_BUS};
			default:                return {24'd0, dev_readdata8[dev]};
		endcase
	endfunction

	// entered and left 5 ns after a rising edge
	task automatic run_transaction(input int t);
		logic [31:0]         op;
		int                  nodata_cycles;
		int                  waited;
		io_hub_pkg::dev_id_t exp_dev;
		logic                exp_io32;
		io_hub_pkg::byte_t   exp_cfg;
		op            = golden[t*FIELDS];
		nodata_cycles = int'(golden[t*FIELDS+4]);
		exp_dev       = io_hub_pkg::dev_id_t'(golden[t*FIELDS+5][3:0]);
		exp_io32      = golden[t*FIELDS+6][0];
		exp_cfg       = golden[t*FIELDS+7][7:0];
		bus_address   = golden[t*FIELDS+1][15:0];
		bus_datasize  = golden[t*FIELDS+2][2:0];
		bus_writedata = golden[t*FIELDS+3];
		new_read_data();
		if (op == 1 && nodata_cycles > 0) begin
			ide0_nodata = exp_dev == io_hub_pkg::DEV_IDE0;
			ide1_nodata = exp_dev == io_hub_pkg::DEV_IDE1;
		end
		@(posedge clk_sys);
		#5;
		compare_value("dev_sel", 32'(dev_sel), 32'(exp_dev));
		compare_value("bus_io32", 32'(bus_io32), 32'(exp_io32));
		bus_read  = op == 1;
		bus_write = op == 2;
		#1;
		compare_value("dev_read", 32'(dev_read), 32'(strobe_mask(exp_dev, op == 1)));
		compare_value("dev_write", 32'(dev_write), 32'(strobe_mask(exp_dev, op == 2)));
		if (op == 1)
			compare_value("bus_readdata", bus_readdata, expected_readdata(exp_dev));
		@(posedge clk_sys);
		#5;
		bus_read  = 1'b0;
		bus_write = 1'b0;
		if (nodata_cycles > 0) begin
			repeat (nodata_cycles - 1) begin
				#1;
				compare_value("bus_wait", 32'(bus_wait), 32'd1);
				compare_value("dev_read", 32'(dev_read), 32'(strobe_mask(exp_dev, 1'b1)));
				@(posedge clk_sys);
				#5;
			end
			ide0_nodata = 1'b0;
			ide1_nodata = 1'b0;
			#1;
			compare_value("bus_wait", 32'(bus_wait), 32'd1); // still stalled this cycle
			compare_value("dev_read", 32'(dev_read), 32'(strobe_mask(exp_dev, 1'b1)));
			waited = 0;
			while (bus_wait) begin
				@(posedge clk_sys);
				#5;
				waited++;
			end
			compare_value("cycles from data ready to wait end", 32'(waited), 32'd1);
			compare_value("bus_readdata", bus_readdata, expected_readdata(exp_dev));
		end
		#1;
		compare_value("syscfg", 32'(syscfg), 32'(exp_cfg));
		@(posedge clk_sys);
		#5;
	endtask

	initial begin
		clk_sys       = 1'b0;
		reset         = 1'b1;
		bus_address   = '0;
		bus_read      = 1'b0;
		bus_write     = 1'b0;
		bus_datasize  = '0;
		bus_writedata = '0;
		ide0_nodata   = 1'b0;
		ide1_nodata   = 1'b0;
		seed          = 80;
		new_read_data();
		for (int i = 0; i < MAX_WORDS; i++)
			golden[i] = '1; // all ones marks the end
		$readmemh("io_hub_golden.txt", golden);
		num_txn = 0;
		while (num_txn * FIELDS < MAX_WORDS && golden[num_txn*FIELDS] != '1)
			num_txn++;
		cycle_limit = 20 * num_txn + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#5;
		reset = 1'b0;
		compare_value("syscfg after reset", 32'(syscfg), 32'h0000_00A2);
		compare_value("dev_sel after reset", 32'(dev_sel), 32'(io_hub_pkg::DEV_NONE));
		for (int t = 0; t < num_txn; t++)
			run_transaction(t);
		if (num_txn > 0 && dut.hub_checks.fail_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			if (num_txn == 0)
				$display("golden file holds no transactions");
			else
				$display("bound assertion on the DUT failed");
			$display("STATUS: FAIL");
			$fatal(1, "run failed");
		end
	end

endmodule

`default_nettype wire

// File: io_hub_golden.txt
// op (0 idle, 1 read, 2 write) address datasize writedata nodata_cycles
// expected: dev code, io32, syscfg (all hex)
1 0000 1 00000000 0 2 0 a2
1 000f 1 00000000 0 2 0 a2
1 0010 1 00000000 0 0 0 a2
1 0080 1 00000000 0 2 0 a2
1 008f 1 00000000 0 2 0 a2
1 00c0 1 00000000 0 2 0 a2
1 00df 1 00000000 0 2 0 a2
1 0020 1 00000000 0 3 0 a2
1 00a1 1 00000000 0 3 0 a2
1 0040 1 00000000 0 4 0 a2
1 0043 1 00000000 0 4 0 a2
1 0061 1 00000000 0 4 0 a2
1 0060 1 00000000 0 5 0 a2
1 0067 1 00000000 0 5 0 a2
1 009f 1 00000000 0 5 0 a2
1 0070 1 00000000 0 6 0 a2
1 0071 1 00000000 0 6 0 a2
1 0220 1 00000000 0 7 0 a2
1 038b 1 00000000 0 7 0 a2
1 03f8 1 00000000 0 8 0 a2
1 03ff 1 00000000 0 8 0 a2
1 02f8 1 00000000 0 9 0 a2
1 0330 1 00000000 0 a 0 a2
1 03b0 1 00000000 0 b 0 a2
1 03df 1 00000000 0 b 0 a2
1 0201 1 00000000 0 c 0 a2
1 0202 1 00000000 0 0 0 a2
1 03e0 1 00000000 0 0 0 a2
2 0060 1 000000c3 0 5 0 a2
0 0330 1 00000000 0 a 0 a2
1 8888 4 00000000 0 f 1 a2
1 03f0 1 00000000 0 1 0 00
1 03f7 1 00000000 0 1 0 00
1 03f6 1 00000000 0 d 0 00
1 01f0 4 00000000 0 d 1 00
1 01f7 4 00000000 0 d 1 00
1 0376 1 00000000 0 e 0 00
1 0170 4 00000000 0 e 1 00
1 01f0 4 00000000 3 d 1 00
1 0170 4 00000000 1 e 1 00
2 01f0 4 deadbeef 0 d 1 00
2 8888 2 0000a155 0 f 1 55
2 8888 2 0000a066 0 f 1 55
2 8888 4 0000a177 0 f 1 55
2 8888 2 0000a13c 0 f 1 3c
1 01f4 4 00000000 0 d 1 3c
1 03f0 1 00000000 0 1 0 3c

// File: project.f
io_hub_pkg.sv
io_sel_if.sv
io_port_decoder.sv
sys_ctl_port.sv
io_response.sv
io_hub.sv
io_hub_assert.sv
tb_io_hub.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --timing --assert
TOP       = tb_io_hub
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_TEXT = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
